// ==== logic/beeb_pkg.sv ====
/*
 * Shared widths, vector types, bus structs and memory-map constants
 * for the BBC Micro memory and analog-input platform.
 * Referenced by scoped name from every RTL block and the testbench.
 */
`default_nettype none

package beeb_pkg;

	// ============================================================
	// widths and limits
	// ============================================================

	// core bus, top bit picks ram
	localparam int addr_w     = 19;
	// sixteen 16 KB rom slots
	localparam int rom_addr_w = 18;
	localparam int bank_w     = 4;
	localparam int slot_w     = 4;
	localparam int offset_w   = 14;
	localparam int ram_bytes  = 212992;

	// mouse emulation bounds
	localparam int delta_limit = 10;
	localparam int pos_min     = -128;
	localparam int pos_max     = 127;

	// ============================================================
	// vector types
	// ============================================================

	typedef logic [7:0]            byte_t;
	typedef logic [addr_w-1:0]     bus_addr_t;
	typedef logic [rom_addr_w-1:0] rom_addr_t;
	typedef logic [bank_w-1:0]     bank_t;
	typedef logic [slot_w-1:0]     slot_t;
	typedef logic [7:0]            axis8_t;
	typedef logic [11:0]           axis12_t;
	typedef logic signed [8:0]     mouse_pos_t;

	// ============================================================
	// bus and config structs
	// ============================================================

	// single access on the shared memory port
	typedef struct packed {
		bus_addr_t addr;
		byte_t     wdata;
		logic      we;
	} mem_req_t;

	// image loader write, physical rom address
	typedef struct packed {
		rom_addr_t addr;
		byte_t     data;
	} load_req_t;

	typedef struct packed {
		logic model_master;
		logic mmfs_v2;
		logic mouse_off;
		logic swap_joy;
	} beeb_cfg_t;

	// stb toggles once per new packet
	typedef struct packed {
		logic       stb;
		mouse_pos_t dx;
		mouse_pos_t dy;
		logic [1:0] btn;
	} mouse_pkt_t;

	typedef struct packed {
		axis8_t x;
		axis8_t y;
		logic   fire;
		logic   any_button;
	} joy_in_t;

	// machine side stick, fire active low
	typedef struct packed {
		axis12_t x;
		axis12_t y;
		logic    fire_n;
	} axis_out_t;

	typedef enum logic [1:0] {
		st_idle,
		st_load_access,
		st_core_access,
		st_wait_release
	} arb_state_t;

endpackage

`default_nettype wire

// ==== logic/rom_bank_map.sv ====
/*
 * Paged bank to physical ROM slot table.
 * Purely combinational, looked up with the core address bank bits
 * and the latched machine model.
 */
`timescale 1ns/1ps
`default_nettype none

module rom_bank_map (
	input  logic            model_master,
	input  logic            mmfs_v2,
	input  beeb_pkg::bank_t bank,
	output beeb_pkg::slot_t slot,
	output logic            present
);

	// ============================================================
	// slot layout
	// ============================================================
	// model b uses slots 0..4 and 14
	// master uses slots 5..13 and 15

	always_comb begin
		slot    = '0;
		present = 1'b0;
		if (!model_master) begin
			case (bank)
				4'd3: begin
					// dfs
					slot    = 4'd4;
					present = 1'b1;
				end
				4'd4: begin
					// os 1.2 high rom
					slot    = 4'd0;
					present = 1'b1;
				end
				4'd8: begin
					// swmmfs lives in split rom/ram space
					// so the slot is mapped but never read back here
					slot    = mmfs_v2 ? 4'd14 : 4'd1;
					present = 1'b0;
				end
				4'd14: begin
					slot    = 4'd2;
					present = 1'b1;
				end
				4'd15: begin
					// basic
					slot    = 4'd3;
					present = 1'b1;
				end
				default: begin
					slot    = '0;
					present = 1'b0;
				end
			endcase
		end else begin
			case (bank)
				4'd3: begin
					// mammfs v1 or v2
					slot    = mmfs_v2 ? 4'd15 : 4'd5;
					present = 1'b1;
				end
				4'd4: begin
					// mos high rom
					slot    = 4'd6;
					present = 1'b1;
				end
				4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15: begin
					// paged roms packed two slots down
					slot    = bank - 4'd2;
					present = 1'b1;
				end
				default: begin
					slot    = '0;
					present = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
/*
 * Two-port four-phase req/ack arbiter for the single memory port.
 * Loader wins when both are pending in idle. Ack rises two cycles
 * after req is seen and falls one cycle after req drops.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 load_req,
	input  beeb_pkg::load_req_t  load_pkt,
	output logic                 load_ack,
	input  logic                 core_req,
	input  beeb_pkg::mem_req_t   core_pkt,
	output logic                 core_ack,
	output beeb_pkg::byte_t      core_rdata,
	output logic                 load_grant,
	output logic                 mem_en,
	output beeb_pkg::mem_req_t   mem_pkt,
	input  beeb_pkg::byte_t      mem_rdata
);

	beeb_pkg::arb_state_t state;
	beeb_pkg::mem_req_t   load_word;

	// loader always writes, address sits in rom space
	always_comb begin
		load_word.addr  = {1'b0, load_pkt.addr};
		load_word.wdata = load_pkt.data;
		load_word.we    = 1'b1;
	end

	assign load_grant = (state == beeb_pkg::st_load_access);

	// ============================================================
	// grant fsm
	// ============================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= beeb_pkg::st_idle;
			mem_en   <= 1'b0;
			load_ack <= 1'b0;
			core_ack <= 1'b0;
		end else begin
			case (state)
				beeb_pkg::st_idle: begin
					if (load_req) begin
						state  <= beeb_pkg::st_load_access;
						mem_en <= 1'b1;
					end else if (core_req) begin
						state  <= beeb_pkg::st_core_access;
						mem_en <= 1'b1;
					end
				end
				beeb_pkg::st_load_access, beeb_pkg::st_core_access: begin
					// first cycle memory acts, second cycle data is back
					if (mem_en) begin
						mem_en <= 1'b0;
					end else begin
						state <= beeb_pkg::st_wait_release;
						if (state == beeb_pkg::st_load_access)
							load_ack <= 1'b1;
						else
							core_ack <= 1'b1;
					end
				end
				beeb_pkg::st_wait_release: begin
					// hold ack until the owner lets go
					if (load_ack && !load_req) begin
						load_ack <= 1'b0;
						state    <= beeb_pkg::st_idle;
					end else if (core_ack && !core_req) begin
						core_ack <= 1'b0;
						state    <= beeb_pkg::st_idle;
					end
				end
				default: state <= beeb_pkg::st_idle;
			endcase
		end
	end

	// payload side
	always_ff @(posedge clk_sys) begin
		// request latched while idle, stable through the access
		if (state == beeb_pkg::st_idle)
			mem_pkt <= load_req ? load_word : core_pkt;
		// read byte captured with the ack edge
		if (state == beeb_pkg::st_core_access && !mem_en)
			core_rdata <= mem_rdata;
	end

endmodule

`default_nettype wire

// ==== logic/beeb_memory.sv ====
/*
 * ROM and RAM stores behind the shared memory port.
 * Holds the latched machine model, maps core ROM reads through the
 * bank table and returns read data one cycle after mem_en.
 */
`timescale 1ns/1ps
`default_nettype none

module beeb_memory (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                sys_reset,
	input  beeb_pkg::beeb_cfg_t cfg,
	input  logic                mem_en,
	input  beeb_pkg::mem_req_t  mem_pkt,
	input  logic                from_loader,
	output beeb_pkg::byte_t     mem_rdata
);

	beeb_pkg::byte_t rom [2**beeb_pkg::rom_addr_w];
	beeb_pkg::byte_t ram [beeb_pkg::ram_bytes];

	logic                model_master;
	beeb_pkg::bank_t     bank;
	beeb_pkg::slot_t     slot;
	logic                present;
	logic                ram_sel;
	beeb_pkg::rom_addr_t rom_rd_addr;
	logic                rom_we;
	logic                ram_we;

	beeb_pkg::byte_t rom_q;
	beeb_pkg::byte_t ram_q;
	logic            ram_sel_q;
	logic            present_q;

	// model only follows the setting while the machine is in reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			model_master <= 1'b0;
		else if (sys_reset)
			model_master <= cfg.model_master;
	end

	// ============================================================
	// address decode
	// ============================================================
	assign ram_sel = mem_pkt.addr[beeb_pkg::addr_w-1];
	assign bank    = mem_pkt.addr[beeb_pkg::offset_w +: beeb_pkg::bank_w];

	rom_bank_map u_map (
		.model_master (model_master),
		.mmfs_v2      (cfg.mmfs_v2),
		.bank         (bank),
		.slot         (slot),
		.present      (present)
	);

	assign rom_rd_addr = {slot, mem_pkt.addr[beeb_pkg::offset_w-1:0]};

	// loader writes land only during machine reset
	assign rom_we = mem_en && mem_pkt.we && from_loader && sys_reset;
	// core writes to rom space fall on the floor
	assign ram_we = mem_en && mem_pkt.we && !from_loader && ram_sel;

	// ============================================================
	// arrays
	// ============================================================
	always_ff @(posedge clk_sys) begin
		// loader uses the physical slot address
		if (rom_we)
			rom[mem_pkt.addr[beeb_pkg::rom_addr_w-1:0]] <= mem_pkt.wdata;
		if (mem_en)
			rom_q <= rom[rom_rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram[mem_pkt.addr[beeb_pkg::rom_addr_w-1:0]] <= mem_pkt.wdata;
		if (mem_en)
			ram_q <= ram[mem_pkt.addr[beeb_pkg::rom_addr_w-1:0]];
	end

	// source select follows the data by one cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ram_sel_q <= 1'b0;
			present_q <= 1'b0;
		end else if (mem_en) begin
			ram_sel_q <= ram_sel;
			present_q <= present;
		end
	end

	// absent slots read as zero
	always_comb begin
		if (ram_sel_q)
			mem_rdata = ram_q;
		else if (present_q)
			mem_rdata = rom_q;
		else
			mem_rdata = '0;
	end

endmodule

`default_nettype wire

// ==== logic/analog_joystick.sv ====
/*
 * Analog stick inputs for the machine.
 * Mouse packets drive a virtual stick with per-packet clamping and
 * saturation. Both sources convert to inverted 12-bit axes.
 */
`timescale 1ns/1ps
`default_nettype none

module analog_joystick (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 sys_reset,
	input  beeb_pkg::beeb_cfg_t  cfg,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  beeb_pkg::joy_in_t    joy1,
	input  beeb_pkg::joy_in_t    joy2,
	output beeb_pkg::axis_out_t  stick1,
	output beeb_pkg::axis_out_t  stick2
);

	logic                 stb_q;
	logic                 emu_mode;
	beeb_pkg::mouse_pos_t mx;
	beeb_pkg::mouse_pos_t my;
	logic signed [9:0]    nx;
	logic signed [9:0]    ny;
	logic                 pos_clear;

	beeb_pkg::axis8_t    src_x;
	beeb_pkg::axis8_t    src_y;
	logic                src_fire;
	beeb_pkg::axis_out_t stick_a;
	beeb_pkg::axis_out_t stick_b;

	// limit one packet's movement
	function automatic beeb_pkg::mouse_pos_t clamp_delta(input beeb_pkg::mouse_pos_t d);
		if (d > beeb_pkg::delta_limit)
			return beeb_pkg::mouse_pos_t'(beeb_pkg::delta_limit);
		else if (d < -beeb_pkg::delta_limit)
			return beeb_pkg::mouse_pos_t'(-beeb_pkg::delta_limit);
		return d;
	endfunction

	function automatic beeb_pkg::mouse_pos_t saturate_pos(input logic signed [9:0] p);
		if (p < beeb_pkg::pos_min)
			return beeb_pkg::mouse_pos_t'(beeb_pkg::pos_min);
		else if (p > beeb_pkg::pos_max)
			return beeb_pkg::mouse_pos_t'(beeb_pkg::pos_max);
		return beeb_pkg::mouse_pos_t'(p);
	endfunction

	// flip sign bit, invert, then widen with the upper nibble
	function automatic beeb_pkg::axis12_t to_axis12(input beeb_pkg::axis8_t v);
		beeb_pkg::byte_t inv;
		inv = 8'hff - {~v[7], v[6:0]};
		return {inv, inv[7:4]};
	endfunction

	// ============================================================
	// mouse emulation
	// ============================================================
	// y on the mouse runs opposite to the stick
	assign nx = mx + clamp_delta(mouse.dx);
	assign ny = my - clamp_delta(mouse.dy);

	assign pos_clear = joy1.any_button || sys_reset || cfg.mouse_off;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			stb_q    <= 1'b0;
			emu_mode <= 1'b0;
			mx       <= '0;
			my       <= '0;
		end else begin
			stb_q <= mouse.stb;
			if (pos_clear) begin
				// back to the real stick
				emu_mode <= 1'b0;
				mx       <= '0;
				my       <= '0;
			end else if (stb_q != mouse.stb) begin
				emu_mode <= 1'b1;
				mx       <= saturate_pos(nx);
				my       <= saturate_pos(ny);
			end
		end
	end

	// ============================================================
	// axis conversion
	// ============================================================
	assign src_x    = emu_mode ? mx[7:0] : joy1.x;
	assign src_y    = emu_mode ? my[7:0] : joy1.y;
	assign src_fire = emu_mode ? |mouse.btn : joy1.fire;

	always_comb begin
		stick_a.x      = to_axis12(src_x);
		stick_a.y      = to_axis12(src_y);
		stick_a.fire_n = ~src_fire;
		stick_b.x      = to_axis12(joy2.x);
		stick_b.y      = to_axis12(joy2.y);
		stick_b.fire_n = ~joy2.fire;
	end

	// optional swap of the two sticks
	assign stick1 = cfg.swap_joy ? stick_b : stick_a;
	assign stick2 = cfg.swap_joy ? stick_a : stick_b;

endmodule

`default_nettype wire

// ==== logic/beeb_platform.sv ====
/*
 * Platform top joining the memory arbiter, the ROM/RAM stores and
 * the analog stick block. Loader and core bus each use a
 * four-phase req/ack handshake onto the one memory port.
 */
`timescale 1ns/1ps
`default_nettype none

module beeb_platform (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 sys_reset,
	input  beeb_pkg::beeb_cfg_t  cfg,
	input  logic                 load_req,
	input  beeb_pkg::load_req_t  load_pkt,
	output logic                 load_ack,
	input  logic                 core_req,
	input  beeb_pkg::mem_req_t   core_pkt,
	output logic                 core_ack,
	output beeb_pkg::byte_t      core_rdata,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  beeb_pkg::joy_in_t    joy1,
	input  beeb_pkg::joy_in_t    joy2,
	output beeb_pkg::axis_out_t  stick1,
	output beeb_pkg::axis_out_t  stick2
);

	// shared memory port
	logic               mem_en;
	beeb_pkg::mem_req_t mem_pkt;
	beeb_pkg::byte_t    mem_rdata;
	logic               load_grant;

	mem_arbiter u_arb (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.load_req   (load_req),
		.load_pkt   (load_pkt),
		.load_ack   (load_ack),
		.core_req   (core_req),
		.core_pkt   (core_pkt),
		.core_ack   (core_ack),
		.core_rdata (core_rdata),
		.load_grant (load_grant),
		.mem_en     (mem_en),
		.mem_pkt    (mem_pkt),
		.mem_rdata  (mem_rdata)
	);

	beeb_memory u_mem (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.sys_reset   (sys_reset),
		.cfg         (cfg),
		.mem_en      (mem_en),
		.mem_pkt     (mem_pkt),
		.from_loader (load_grant),
		.mem_rdata   (mem_rdata)
	);

	analog_joystick u_joy (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sys_reset (sys_reset),
		.cfg       (cfg),
		.mouse     (mouse),
		.joy1      (joy1),
		.joy2      (joy2),
		.stick1    (stick1),
		.stick2    (stick2)
	);

endmodule

`default_nettype wire

// ==== sim/beeb_props.sv ====
/*
 * Concurrent checks on the loader and core four-phase handshakes.
 * Bound into mem_arbiter. fail_count totals the assertion failures.
 */
`timescale 1ns/1ps
`default_nettype none

module beeb_props (
	input logic clk_sys,
	input logic rst_n,
	input logic load_req,
	input logic load_ack,
	input logic core_req,
	input logic core_ack
);

	int fail_count = 0;

	// ============================================================
	// loader port
	// ============================================================
	// ack only answers a live request
	load_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(load_ack) |-> $past(load_req))
		else begin
			$error("load_ack rose with no load_req");
			fail_count++;
		end

	// req may only drop once acked
	load_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(load_req) |-> load_ack)
		else begin
			$error("load_req dropped before load_ack");
			fail_count++;
		end

	load_ack_release: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(load_req) |=> !load_ack)
		else begin
			$error("load_ack still high a cycle after load_req fell");
			fail_count++;
		end

	// ============================================================
	// core port
	// ============================================================
	core_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(core_ack) |-> $past(core_req))
		else begin
			$error("core_ack rose with no core_req");
			fail_count++;
		end

	core_req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(core_req) |-> core_ack)
		else begin
			$error("core_req dropped before core_ack");
			fail_count++;
		end

	core_ack_release: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(core_req) |=> !core_ack)
		else begin
			$error("core_ack still high a cycle after core_req fell");
			fail_count++;
		end

	// one owner of the memory port at a time
	acks_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(load_ack && core_ack))
		else begin
			$error("load_ack and core_ack high together");
			fail_count++;
		end

endmodule

bind mem_arbiter beeb_props u_props (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.load_req (load_req),
	.load_ack (load_ack),
	.core_req (core_req),
	.core_ack (core_ack)
);

`default_nettype wire

// ==== sim/tb_beeb_platform.sv ====
/*
 * Directed testbench for the platform top. Covers ROM loading and the
 * bank map, RAM access, port contention and the analog stick path.
 * Compile with sources.f, top module tb_beeb_platform.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_beeb_platform;

	// about 90 handshakes of ~6 cycles plus the stick steps, far below this
	localparam int cycle_limit = 20000;
	// per handshake phase
	localparam int hs_limit = 50;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 sys_reset;
	beeb_pkg::beeb_cfg_t  cfg;
	logic                 load_req;
	beeb_pkg::load_req_t  load_pkt;
	logic                 load_ack;
	logic                 core_req;
	beeb_pkg::mem_req_t   core_pkt;
	logic                 core_ack;
	beeb_pkg::byte_t      core_rdata;
	beeb_pkg::mouse_pkt_t mouse;
	beeb_pkg::joy_in_t    joy1;
	beeb_pkg::joy_in_t    joy2;
	beeb_pkg::axis_out_t  stick1;
	beeb_pkg::axis_out_t  stick2;

	integer seed = 59;
	int     checks = 0;
	int     errors = 0;
	int     cycles = 0;

	// one byte per rom slot
	logic [13:0]         rom_off [16];
	beeb_pkg::byte_t     rom_dat [16];
	beeb_pkg::bus_addr_t ram_addr [8];
	beeb_pkg::byte_t     ram_dat [8];
	// expected mouse position
	int px;
	int py;

	beeb_platform uut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.sys_reset  (sys_reset),
		.cfg        (cfg),
		.load_req   (load_req),
		.load_pkt   (load_pkt),
		.load_ack   (load_ack),
		.core_req   (core_req),
		.core_pkt   (core_pkt),
		.core_ack   (core_ack),
		.core_rdata (core_rdata),
		.mouse      (mouse),
		.joy1       (joy1),
		.joy2       (joy2),
		.stick1     (stick1),
		.stick2     (stick2)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("run stopped, still going after %0d clock cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_byte(input string name, input beeb_pkg::byte_t exp,
			input beeb_pkg::byte_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %02h actual %02h", name, exp, act);
		end
	endtask

	// x, y and fire_n shown in that order
	task automatic check_stick(input string name, input beeb_pkg::axis_out_t exp,
			input beeb_pkg::axis_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %03h/%03h/%b actual %03h/%03h/%b",
				name, exp.x, exp.y, exp.fire_n, act.x, act.y, act.fire_n);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// ============================================================
	// reference model
	// ============================================================
	// paged bank to slot, 0 when no rom answers
	function automatic logic lookup_slot(input logic master, input logic v2, input int bank,
			output int slot);
		slot = 0;
		if (!master) begin
			case (bank)
				3: slot = 4;
				4: slot = 0;
				14: slot = 2;
				15: slot = 3;
				default: return 1'b0;
			endcase
		end else begin
			if (bank == 3)
				slot = v2 ? 15 : 5;
			else if (bank == 4)
				slot = 6;
			else if (bank >= 9)
				slot = bank - 2;
			else
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// 255 minus sign-flipped byte, low nibble repeats the high one
	function automatic beeb_pkg::axis12_t machine_axis(input beeb_pkg::byte_t v);
		beeb_pkg::byte_t inv;
		inv = 8'd255 - (v ^ 8'h80);
		return {inv, inv[7:4]};
	endfunction

	function automatic beeb_pkg::axis_out_t expected_stick(input beeb_pkg::byte_t x,
			input beeb_pkg::byte_t y, input logic fire);
		beeb_pkg::axis_out_t s;
		s.x      = machine_axis(x);
		s.y      = machine_axis(y);
		s.fire_n = ~fire;
		return s;
	endfunction

	function automatic int clamp_move(input int d);
		if (d > beeb_pkg::delta_limit)
			return beeb_pkg::delta_limit;
		if (d < -beeb_pkg::delta_limit)
			return -beeb_pkg::delta_limit;
		return d;
	endfunction

	function automatic int limit_pos(input int p);
		if (p > beeb_pkg::pos_max)
			return beeb_pkg::pos_max;
		if (p < beeb_pkg::pos_min)
			return beeb_pkg::pos_min;
		return p;
	endfunction

	// ============================================================
	// four-phase helpers
	// ============================================================
	// n counts falling edges until ack reaches level
	task automatic wait_ack(input logic core, input logic level, input string name,
			output int n);
		logic ack;
		n   = 0;
		ack = ~level;
		while (ack !== level && n < hs_limit) begin
			@(negedge clk_sys);
			n++;
			ack = core ? core_ack : load_ack;
		end
		if (ack !== level) begin
			errors++;
			$display("%s: %s ack did not go to %0d within %0d cycles, handshake timed out",
				name, core ? "core" : "loader", level, hs_limit);
		end
	endtask

	task automatic load_byte(input beeb_pkg::rom_addr_t addr, input beeb_pkg::byte_t data,
			input string name);
		int n;
		@(negedge clk_sys);
		load_pkt.addr = addr;
		load_pkt.data = data;
		load_req      = 1'b1;
		wait_ack(1'b0, 1'b1, name, n);
		// grant edge follows the req edge, ack two later
		check_count({name, " ack latency"}, 2, n - 1);
		load_req = 1'b0;
		wait_ack(1'b0, 1'b0, name, n);
		check_count({name, " release"}, 1, n);
	endtask

	task automatic core_access(input beeb_pkg::bus_addr_t addr, input beeb_pkg::byte_t wdata,
			input logic we, input string name, output beeb_pkg::byte_t rdata);
		int n;
		@(negedge clk_sys);
		core_pkt.addr  = addr;
		core_pkt.wdata = wdata;
		core_pkt.we    = we;
		core_req       = 1'b1;
		wait_ack(1'b1, 1'b1, name, n);
		check_count({name, " ack latency"}, 2, n - 1);
		rdata    = core_rdata;
		core_req = 1'b0;
		wait_ack(1'b1, 1'b0, name, n);
		check_count({name, " release"}, 1, n);
	endtask

	task automatic read_all_banks(input string name, input logic master, input logic v2);
		int                  b;
		int                  s;
		logic                p;
		beeb_pkg::byte_t     rd;
		beeb_pkg::bus_addr_t a;
		for (b = 0; b < 16; b++) begin
			p = lookup_slot(master, v2, b, s);
			a = {1'b0, beeb_pkg::bank_t'(b), rom_off[s]};
			core_access(a, 8'h00, 1'b0, name, rd);
			check_byte($sformatf("%s bank %0d", name, b), p ? rom_dat[s] : 8'h00, rd);
		end
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic rom_load_model_b();
		int s;
		@(negedge clk_sys);
		sys_reset        = 1'b1;
		cfg.model_master = 1'b0;
		cfg.mmfs_v2      = 1'b0;
		repeat (2) @(negedge clk_sys);
		// nonzero data so an absent slot cannot look loaded
		for (s = 0; s < 16; s++) begin
			rom_off[s] = 14'($random(seed));
			rom_dat[s] = 8'($random(seed)) | 8'h01;
			load_byte({beeb_pkg::slot_t'(s), rom_off[s]}, rom_dat[s], "rom load");
		end
		read_all_banks("model b map", 1'b0, 1'b0);
	endtask

	task automatic master_map_and_lock();
		beeb_pkg::byte_t rd;
		@(negedge clk_sys);
		cfg.model_master = 1'b1;
		repeat (2) @(negedge clk_sys);
		read_all_banks("master map v1", 1'b1, 1'b0);
		@(negedge clk_sys);
		cfg.mmfs_v2 = 1'b1;
		read_all_banks("master map v2", 1'b1, 1'b1);
		// machine running, loader is acked but ignored
		// latched model stays master while cfg says model b
		@(negedge clk_sys);
		sys_reset        = 1'b0;
		cfg.model_master = 1'b0;
		load_byte({4'd6, rom_off[6]}, ~rom_dat[6], "late load");
		core_access({1'b0, 4'd4, rom_off[6]}, 8'h00, 1'b0, "late load read", rd);
		check_byte("late load ignored", rom_dat[6], rd);
	endtask

	task automatic ram_and_rom_protect();
		int              i;
		beeb_pkg::byte_t rd;
		// one address per 16 KB stretch keeps them distinct
		for (i = 0; i < 8; i++) begin
			ram_addr[i] = {1'b1, 18'(i * 16384 + ($random(seed) & 16'h3fff))};
			ram_dat[i]  = 8'($random(seed));
			core_access(ram_addr[i], ram_dat[i], 1'b1, "ram write", rd);
		end
		for (i = 0; i < 8; i++) begin
			core_access(ram_addr[i], 8'h00, 1'b0, "ram read", rd);
			check_byte("ram read", ram_dat[i], rd);
		end
		// core stays off the rom even with the machine in reset
		// bank 4 maps to slot 6, bank 6 is slot 6 by physical address
		@(negedge clk_sys);
		cfg.model_master = 1'b1;
		sys_reset        = 1'b1;
		core_access({1'b0, 4'd4, rom_off[6]}, ~rom_dat[6], 1'b1, "core rom write", rd);
		core_access({1'b0, 4'd6, rom_off[6]}, ~rom_dat[6], 1'b1, "core rom write", rd);
		sys_reset = 1'b0;
		core_access({1'b0, 4'd4, rom_off[6]}, 8'h00, 1'b0, "core rom read", rd);
		check_byte("core rom write ignored", rom_dat[6], rd);
	endtask

	task automatic port_contention();
		int n;
		@(negedge clk_sys);
		load_pkt.addr  = {4'd0, rom_off[0]};
		load_pkt.data  = 8'h3c;
		core_pkt.addr  = ram_addr[0];
		core_pkt.wdata = 8'h00;
		core_pkt.we    = 1'b0;
		load_req       = 1'b1;
		core_req       = 1'b1;
		// loader wins from idle
		wait_ack(1'b0, 1'b1, "contention", n);
		check_count("contention loader latency", 2, n - 1);
		check_count("contention core held off", 0, (core_ack === 1'b0) ? 0 : 1);
		load_req = 1'b0;
		wait_ack(1'b0, 1'b0, "contention", n);
		check_count("contention loader release", 1, n);
		// core granted on the edge after the loader lets go
		wait_ack(1'b1, 1'b1, "contention", n);
		check_count("contention core latency", 2, n - 1);
		check_byte("contention core read", ram_dat[0], core_rdata);
		core_req = 1'b0;
		wait_ack(1'b1, 1'b0, "contention", n);
		check_count("contention core release", 1, n);
	endtask

	task automatic send_mouse(input int dx, input int dy, input logic [1:0] btn);
		@(negedge clk_sys);
		mouse.stb = ~mouse.stb;
		mouse.dx  = beeb_pkg::mouse_pos_t'(dx);
		mouse.dy  = beeb_pkg::mouse_pos_t'(dy);
		mouse.btn = btn;
		// mouse y runs against the stick
		px = limit_pos(px + clamp_move(dx));
		py = limit_pos(py - clamp_move(dy));
		@(negedge clk_sys);
		check_stick("mouse stick", expected_stick(8'(px), 8'(py), |btn), stick1);
	endtask

	task automatic mouse_emulation();
		int i;
		px = 0;
		py = 0;
		// drive x to the top rail and y to the bottom rail
		for (i = 0; i < 16; i++)
			send_mouse(100, 37, 2'(i));
		for (i = 0; i < 8; i++)
			send_mouse($random(seed) % 200, $random(seed) % 200, 2'($random(seed)));
		@(negedge clk_sys);
		joy1.x          = 8'($random(seed));
		joy1.y          = 8'($random(seed));
		joy1.fire       = 1'b1;
		joy1.any_button = 1'b1;
		@(negedge clk_sys);
		joy1.any_button = 1'b0;
		@(negedge clk_sys);
		check_stick("joy1 after button", expected_stick(joy1.x, joy1.y, joy1.fire), stick1);
	endtask

	task automatic joystick_swap();
		@(negedge clk_sys);
		joy1.x    = 8'($random(seed));
		joy1.y    = 8'($random(seed));
		joy1.fire = 1'b1;
		joy2.x    = 8'($random(seed));
		joy2.y    = 8'($random(seed));
		joy2.fire = 1'b0;
		@(negedge clk_sys);
		check_stick("stick1 direct", expected_stick(joy1.x, joy1.y, 1'b1), stick1);
		check_stick("stick2 direct", expected_stick(joy2.x, joy2.y, 1'b0), stick2);
		cfg.swap_joy = 1'b1;
		@(negedge clk_sys);
		check_stick("stick1 swapped", expected_stick(joy2.x, joy2.y, 1'b0), stick1);
		check_stick("stick2 swapped", expected_stick(joy1.x, joy1.y, 1'b1), stick2);
		cfg.swap_joy = 1'b0;
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		rst_n     = 1'b0;
		sys_reset = 1'b1;
		cfg       = '0;
		load_req  = 1'b0;
		load_pkt  = '0;
		core_req  = 1'b0;
		core_pkt  = '0;
		mouse     = '0;
		joy1      = '0;
		joy2      = '0;
		px        = 0;
		py        = 0;
		repeat (10) @(negedge clk_sys);
		rst_n     = 1'b1;
		sys_reset = 1'b0;

		rom_load_model_b();
		master_map_and_lock();
		ram_and_rom_protect();
		port_contention();
		mouse_emulation();
		joystick_swap();

		errors = errors + uut.u_arb.u_props.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			uut.u_arb.u_props.fail_count);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/beeb_pkg.sv
logic/rom_bank_map.sv
logic/mem_arbiter.sv
logic/beeb_memory.sv
logic/analog_joystick.sv
logic/beeb_platform.sv
sim/beeb_props.sv
sim/tb_beeb_platform.sv
